/* files.f */
+incdir+include
rtl/pq_pkg.sv
rtl/page_free_list.sv
rtl/queue_ptr_table.sv
rtl/ptr_table_arbiter.sv
rtl/enqueue_ctrl.sv
rtl/queue_memory.sv
rtl/packet_queue_top.sv
bench/packet_queue_properties.sv
bench/packet_queue_tb.sv

/* bench/packet_queue_tb.sv */
// Testbench for the packet queue top level. Runs one table row at a time, so a
// packet is committed before the next row starts and one dequeue is in flight.
`include "pq_defs.svh"

module packet_queue_tb;

    localparam int NUM_ROWS  = 27;
    localparam int LIMIT     = 200 * NUM_ROWS;
    localparam int REF_DEPTH = 128;

    typedef enum logic [1:0] {
        OP_ENQ,
        OP_DEQ,
        OP_PAGES
    } op_t;

    // count is words for an enqueue and requests for a dequeue
    typedef struct packed {
        op_t          op;
        pq_pkg::qid_t qid;
        logic [7:0]   count;
        logic [2:0]   bytes;
    } row_t;

    logic                packet_in;
    logic                rst;
    pq_pkg::pq_ingress_t in_word;
    logic                in_valid;
    logic                in_ready;
    pq_pkg::qid_t        deq_req;
    logic                deq_valid;
    logic                deq_ready;
    pq_pkg::pq_word_t    out_word;
    logic                out_valid;
    pq_pkg::deq_note_t   note;
    logic                note_valid;
    logic                deq_empty;
    pq_pkg::page_cnt_t   pages_free;

    row_t                        table_rows [NUM_ROWS];
    logic [`PQ_DATA_BYTES*8-1:0] ref_data  [`PQ_NUM_QUEUES][REF_DEPTH];
    pq_pkg::keep_enc_t           ref_keep  [`PQ_NUM_QUEUES][REF_DEPTH];
    logic                        ref_last  [`PQ_NUM_QUEUES][REF_DEPTH];
    logic [2:0]                  ref_bytes [`PQ_NUM_QUEUES][REF_DEPTH];
    int                          ref_wr    [`PQ_NUM_QUEUES];
    int                          ref_rd    [`PQ_NUM_QUEUES];

    integer seed   = 32'hf17da718;
    int     cycles = 0;
    int     checks = 0;
    int     errors = 0;

    packet_queue_top uut (
        .packet_in, .rst, .in_word, .in_valid, .in_ready,
        .deq_req, .deq_valid, .deq_ready, .out_word, .out_valid,
        .note, .note_valid, .deq_empty, .pages_free
    );

    initial begin
        packet_in = 1'b0;
        forever #20 packet_in = ~packet_in;
    end

    always @(posedge packet_in) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////
    // Stimulus table

    task automatic load_rows();
        // Single word, then a read from the emptied queue
        table_rows[0]  = '{OP_ENQ, 2'd0, 8'd1, 3'd3};
        table_rows[1]  = '{OP_DEQ, 2'd0, 8'd1, 3'd0};
        table_rows[2]  = '{OP_DEQ, 2'd0, 8'd1, 3'd0};
        // Six words across a page boundary
        table_rows[3]  = '{OP_ENQ, 2'd1, 8'd6, 3'd4};
        table_rows[4]  = '{OP_DEQ, 2'd1, 8'd6, 3'd0};
        // Interleaved queues
        table_rows[5]  = '{OP_ENQ, 2'd2, 8'd3, 3'd2};
        table_rows[6]  = '{OP_ENQ, 2'd3, 8'd2, 3'd1};
        table_rows[7]  = '{OP_ENQ, 2'd2, 8'd2, 3'd4};
        table_rows[8]  = '{OP_ENQ, 2'd3, 8'd5, 3'd3};
        table_rows[9]  = '{OP_DEQ, 2'd3, 8'd3, 3'd0};
        table_rows[10] = '{OP_DEQ, 2'd2, 8'd5, 3'd0};
        table_rows[11] = '{OP_DEQ, 2'd3, 8'd4, 3'd0};
        table_rows[12] = '{OP_DEQ, 2'd3, 8'd1, 3'd0};
        table_rows[13] = '{OP_ENQ, 2'd0, 8'd4, 3'd2};
        table_rows[14] = '{OP_PAGES, 2'd0, 8'd0, 3'd0};
        // Enough traffic to cycle more pages than the memory holds
        table_rows[15] = '{OP_ENQ, 2'd1, 8'd8, 3'd4};
        table_rows[16] = '{OP_DEQ, 2'd1, 8'd8, 3'd0};
        table_rows[17] = '{OP_ENQ, 2'd2, 8'd8, 3'd1};
        table_rows[18] = '{OP_DEQ, 2'd2, 8'd8, 3'd0};
        table_rows[19] = '{OP_ENQ, 2'd0, 8'd8, 3'd3};
        table_rows[20] = '{OP_DEQ, 2'd0, 8'd12, 3'd0};
        table_rows[21] = '{OP_ENQ, 2'd3, 8'd12, 3'd2};
        table_rows[22] = '{OP_DEQ, 2'd3, 8'd12, 3'd0};
        table_rows[23] = '{OP_ENQ, 2'd1, 8'd12, 3'd4};
        table_rows[24] = '{OP_DEQ, 2'd1, 8'd12, 3'd0};
        table_rows[25] = '{OP_PAGES, 2'd0, 8'd0, 3'd0};
        table_rows[26] = '{OP_DEQ, 2'd2, 8'd1, 3'd0};
    endtask

    // A queue takes a page at its first word and after every fourth word,
    // and gives one back each time a fourth word leaves
    function automatic int pages_held();
        int held;
        held = 0;
        for (int q = 0; q < `PQ_NUM_QUEUES; q++) begin
            if (ref_wr[q] > 0) begin
                held = held + ref_wr[q] / `PQ_WORDS_PER_PAGE + 1
                       - ref_rd[q] / `PQ_WORDS_PER_PAGE;
            end
        end
        return held;
    endfunction

    ////////////////////
    // Drivers

    task automatic send_packet(input pq_pkg::qid_t qid, input int len, input int bytes);
        pq_pkg::pq_ingress_t w;
        int                  slot;
        for (int i = 0; i < len; i++) begin
            w               = '0;
            w.qid           = qid;
            w.word.data     = $random(seed);
            w.word.last     = (i == len - 1);
            w.word.keep_enc = (i == len - 1) ? pq_pkg::keep_enc_t'(bytes) : '0;
            slot            = ref_wr[qid];
            ref_data[qid][slot]  = w.word.data;
            ref_keep[qid][slot]  = w.word.keep_enc;
            ref_last[qid][slot]  = w.word.last;
            ref_bytes[qid][slot] = (i == len - 1) ? 3'(bytes) : 3'(`PQ_DATA_BYTES);
            ref_wr[qid]     = slot + 1;
            in_word  = w;
            in_valid = 1'b1;
            while (!in_ready) @(negedge packet_in);
            @(negedge packet_in);
        end
        in_valid = 1'b0;
        // in_ready returns once the commit handshake is over
        while (!in_ready) @(negedge packet_in);
    endtask

    task automatic pull_word(input pq_pkg::qid_t qid);
        int   slot;
        logic empty_exp;
        slot      = ref_rd[qid];
        empty_exp = (ref_rd[qid] == ref_wr[qid]);
        while (!deq_ready) @(negedge packet_in);
        deq_req   = qid;
        deq_valid = 1'b1;
        @(negedge packet_in);
        deq_valid = 1'b0;
        while (!out_valid && !deq_empty) @(negedge packet_in);
        checks = checks + 1;
        if (out_valid && deq_empty) begin
            $display("Word and empty flag came out together for queue %0d", qid);
            errors = errors + 1;
        end
        if (empty_exp) begin
            if (deq_empty !== 1'b1) begin
                $display("[FAIL] %0t deq_empty got %b expected 1 on queue %0d",
                         $time, deq_empty, qid);
                errors = errors + 1;
            end
        end else if (deq_empty) begin
            $display("[FAIL] %0t deq_empty got %b expected 0 on queue %0d",
                     $time, deq_empty, qid);
            errors = errors + 1;
        end else begin
            if (out_word.data !== ref_data[qid][slot]) begin
                $display("[FAIL] %0t out_word.data got %h expected %h",
                         $time, out_word.data, ref_data[qid][slot]);
                errors = errors + 1;
            end
            if (out_word.keep_enc !== ref_keep[qid][slot]) begin
                $display("[FAIL] %0t out_word.keep_enc got %0d expected %0d",
                         $time, out_word.keep_enc, ref_keep[qid][slot]);
                errors = errors + 1;
            end
            if (out_word.last !== ref_last[qid][slot]) begin
                $display("[FAIL] %0t out_word.last got %b expected %b",
                         $time, out_word.last, ref_last[qid][slot]);
                errors = errors + 1;
            end
            if (note_valid !== 1'b1) begin
                $display("[FAIL] %0t note_valid got %b expected 1", $time, note_valid);
                errors = errors + 1;
            end
            if (note.valid_bytes !== ref_bytes[qid][slot]) begin
                $display("[FAIL] %0t note.valid_bytes got %0d expected %0d",
                         $time, note.valid_bytes, ref_bytes[qid][slot]);
                errors = errors + 1;
            end
            if (note.last !== ref_last[qid][slot]) begin
                $display("[FAIL] %0t note.last got %b expected %b",
                         $time, note.last, ref_last[qid][slot]);
                errors = errors + 1;
            end
            if (note.qid !== qid) begin
                $display("[FAIL] %0t note.qid got %0d expected %0d", $time, note.qid, qid);
                errors = errors + 1;
            end
            ref_rd[qid] = slot + 1;
        end
        // Nothing more may come out until the next request can be taken
        @(negedge packet_in);
        while (!deq_ready || out_valid || deq_empty) begin
            if (out_valid || deq_empty) begin
                $display("Extra output pulse after dequeue of queue %0d", qid);
                errors = errors + 1;
            end
            @(negedge packet_in);
        end
    endtask

    ////////////////////
    // Main sequence

    initial begin
        rst       = 1'b1;
        in_word   = '0;
        in_valid  = 1'b0;
        deq_req   = '0;
        deq_valid = 1'b0;
        for (int q = 0; q < `PQ_NUM_QUEUES; q++) begin
            ref_wr[q] = 0;
            ref_rd[q] = 0;
        end
        load_rows();
        repeat (5) @(posedge packet_in);
        @(negedge packet_in);
        rst = 1'b0;
        @(negedge packet_in);

        checks = checks + 1;
        if (out_valid !== 1'b0) begin
            $display("[FAIL] %0t out_valid got %b expected 0", $time, out_valid);
            errors = errors + 1;
        end
        if (note_valid !== 1'b0) begin
            $display("[FAIL] %0t note_valid got %b expected 0", $time, note_valid);
            errors = errors + 1;
        end
        if (deq_empty !== 1'b0) begin
            $display("[FAIL] %0t deq_empty got %b expected 0", $time, deq_empty);
            errors = errors + 1;
        end
        if (in_ready !== 1'b1) begin
            $display("[FAIL] %0t in_ready got %b expected 1", $time, in_ready);
            errors = errors + 1;
        end
        if (deq_ready !== 1'b1) begin
            $display("[FAIL] %0t deq_ready got %b expected 1", $time, deq_ready);
            errors = errors + 1;
        end
        if (pages_free != `PQ_NUM_PAGES) begin
            $display("[FAIL] %0t pages_free got %0d expected %0d",
                     $time, pages_free, `PQ_NUM_PAGES);
            errors = errors + 1;
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            case (table_rows[r].op)
                OP_ENQ: begin
                    send_packet(table_rows[r].qid, table_rows[r].count, table_rows[r].bytes);
                end
                OP_DEQ: begin
                    for (int k = 0; k < table_rows[r].count; k++) begin
                        pull_word(table_rows[r].qid);
                    end
                end
                default: begin
                    checks = checks + 1;
                    if (pages_free != `PQ_NUM_PAGES - pages_held()) begin
                        $display("[FAIL] %0t pages_free got %0d expected %0d",
                                 $time, pages_free, `PQ_NUM_PAGES - pages_held());
                        errors = errors + 1;
                    end
                end
            endcase
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* bench/packet_queue_properties.sv */
// Concurrent checks on the dequeue side of queue_memory. They rely on a single
// dequeue in flight, which queue_memory keeps through deq_ready.
module packet_queue_properties (
    input logic packet_in,
    input logic rst,
    input logic out_valid,
    input logic note_valid,
    input logic deq_empty,
    input logic ptr_req,
    input logic ptr_ack
);

    // Word and notification leave together
    a_out_note: assert property (@(posedge packet_in) disable iff (rst)
        out_valid == note_valid)
        else $error("out_valid and note_valid differ");

    a_ack_rise: assert property (@(posedge packet_in) disable iff (rst)
        $rose(ptr_ack) |-> ptr_req)
        else $error("pointer table ack rose without a request");

    // Four-phase return to zero
    a_ack_fall: assert property (@(posedge packet_in) disable iff (rst)
        $fell(ptr_ack) |-> !ptr_req)
        else $error("pointer table ack fell while the request was still high");

    a_one_result: assert property (@(posedge packet_in) disable iff (rst)
        !(deq_empty && out_valid))
        else $error("deq_empty and out_valid high together");

endmodule

bind queue_memory packet_queue_properties u_props (
    .packet_in  (packet_in),
    .rst        (rst),
    .out_valid  (out_valid),
    .note_valid (note_valid),
    .deq_empty  (deq_empty),
    .ptr_req    (ptr_req),
    .ptr_ack    (ptr_ack)
);

/* rtl/packet_queue_top.sv */
// Packet queue subsystem. Words enter tagged with a queue id and leave one per
// dequeue request; a packet is visible only after its last word is committed.
module packet_queue_top (
    input  logic                packet_in,
    input  logic                rst,
    input  pq_pkg::pq_ingress_t in_word,
    input  logic                in_valid,
    output logic                in_ready,
    input  pq_pkg::qid_t        deq_req,
    input  logic                deq_valid,
    output logic                deq_ready,
    output pq_pkg::pq_word_t    out_word,
    output logic                out_valid,
    output pq_pkg::deq_note_t   note,
    output logic                note_valid,
    output logic                deq_empty,
    output pq_pkg::page_cnt_t   pages_free
);

    logic             enq_req;
    logic             enq_ack;
    pq_pkg::ptr_req_t enq_cmd;
    pq_pkg::ptr_rsp_t enq_rsp;
    logic             pop_req;
    logic             pop_ack;
    pq_pkg::ptr_req_t pop_cmd;
    pq_pkg::ptr_rsp_t pop_rsp;
    logic             tbl_en;
    pq_pkg::ptr_req_t tbl_req;
    pq_pkg::ptr_rsp_t tbl_rsp;
    logic             alloc;
    pq_pkg::page_t    alloc_page;
    logic             avail;
    logic             rel;
    pq_pkg::page_t    rel_page;
    logic             wr_en;
    pq_pkg::pq_ptr_t  wr_addr;
    pq_pkg::pq_word_t wr_word;

    page_free_list u_free (
        .packet_in, .rst, .alloc, .alloc_page, .avail, .rel, .rel_page, .pages_free
    );

    queue_ptr_table u_table (
        .packet_in, .rst, .tbl_en, .tbl_req, .tbl_rsp
    );

    ptr_table_arbiter u_arb (
        .packet_in, .rst,
        .enq_req, .enq_ack, .enq_cmd, .enq_rsp,
        .deq_req (pop_req), .deq_ack (pop_ack), .deq_cmd (pop_cmd), .deq_rsp (pop_rsp),
        .tbl_en, .tbl_req, .tbl_rsp
    );

    enqueue_ctrl u_enq (
        .packet_in, .rst, .in_word, .in_valid, .in_ready,
        .ptr_req (enq_req), .ptr_ack (enq_ack), .ptr_cmd (enq_cmd), .ptr_rsp (enq_rsp),
        .alloc, .alloc_page, .avail, .wr_en, .wr_addr, .wr_word
    );

    queue_memory u_qmem (
        .packet_in, .rst, .wr_en, .wr_addr, .wr_word,
        .deq_req, .deq_valid, .deq_ready,
        .ptr_req (pop_req), .ptr_ack (pop_ack), .ptr_cmd (pop_cmd), .ptr_rsp (pop_rsp),
        .out_word, .out_valid, .note, .note_valid, .deq_empty, .rel, .rel_page
    );

endmodule

/* rtl/queue_memory.sv */
// Word memory and dequeue path. One dequeue in flight; the result appears
// three cycles after the head pop is acknowledged, with no back-pressure.
`include "pq_defs.svh"

module queue_memory (
    input  logic              packet_in,
    input  logic              rst,
    input  logic              wr_en,
    input  pq_pkg::pq_ptr_t   wr_addr,
    input  pq_pkg::pq_word_t  wr_word,
    input  pq_pkg::qid_t      deq_req,
    input  logic              deq_valid,
    output logic              deq_ready,
    output logic              ptr_req,
    input  logic              ptr_ack,
    output pq_pkg::ptr_req_t  ptr_cmd,
    input  pq_pkg::ptr_rsp_t  ptr_rsp,
    output pq_pkg::pq_word_t  out_word,
    output logic              out_valid,
    output pq_pkg::deq_note_t note,
    output logic              note_valid,
    output logic              deq_empty,
    output logic              rel,
    output pq_pkg::page_t     rel_page
);

    localparam int DEPTH = `PQ_NUM_PAGES * `PQ_WORDS_PER_PAGE;

    typedef struct packed {
        pq_pkg::keep_enc_t keep_enc;
        logic              last;
    } len_entry_t;

    logic [`PQ_DATA_BYTES*8-1:0] data_mem [DEPTH];
    len_entry_t                  len_mem  [DEPTH];

    logic                        wr_en_q;
    pq_pkg::pq_ptr_t             wr_addr_q;
    pq_pkg::pq_word_t            wr_word_q;
    logic [`PQ_DATA_BYTES*8-1:0] data_do1;
    logic [`PQ_DATA_BYTES*8-1:0] data_res1;
    len_entry_t                  len_do1;
    len_entry_t                  len_res1;
    logic                        busy;
    pq_pkg::qid_t                deq_qid;
    logic                        pop_done;
    logic [1:0]                  rd_v;

    function automatic pq_pkg::valid_bytes_t to_valid_bytes(input pq_pkg::keep_enc_t k);
        return (k == '0) ? pq_pkg::valid_bytes_t'(`PQ_DATA_BYTES) : pq_pkg::valid_bytes_t'(k);
    endfunction

    assign deq_ready = !busy && !ptr_ack;
    assign pop_done  = ptr_req && ptr_ack;

    always_comb begin
        ptr_cmd     = '0;
        ptr_cmd.op  = pq_pkg::PTR_HEAD_POP;
        ptr_cmd.qid = deq_qid;
    end

    ////////////////////
    // Dequeue control

    always_ff @(posedge packet_in) begin
        if (rst) begin
            busy       <= 1'b0;
            ptr_req    <= 1'b0;
            rd_v       <= '0;
            out_valid  <= 1'b0;
            note_valid <= 1'b0;
            deq_empty  <= 1'b0;
            rel        <= 1'b0;
            wr_en_q    <= 1'b0;
        end else begin
            wr_en_q <= wr_en;
            if (deq_valid && deq_ready) begin
                busy    <= 1'b1;
                ptr_req <= 1'b1;
                deq_qid <= deq_req;
            end
            if (pop_done) begin
                ptr_req <= 1'b0;
            end
            // Read, output register, result
            rd_v       <= {rd_v[0], pop_done && !ptr_rsp.empty};
            out_valid  <= rd_v[1];
            note_valid <= rd_v[1];
            deq_empty  <= pop_done && ptr_rsp.empty;
            rel        <= pop_done && !ptr_rsp.empty && ptr_rsp.page_done;
            if (out_valid || deq_empty) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////
    // Memories and read pipeline

    always_ff @(posedge packet_in) begin
        wr_addr_q <= wr_addr;
        wr_word_q <= wr_word;
        if (wr_en_q) begin
            data_mem[wr_addr_q] <= wr_word_q.data;
            len_mem[wr_addr_q]  <= '{keep_enc: wr_word_q.keep_enc, last: wr_word_q.last};
        end

        // Head address is held by the arbiter while ack is high
        data_do1  <= data_mem[ptr_rsp.ptr];
        len_do1   <= len_mem[ptr_rsp.ptr];
        data_res1 <= data_do1;
        len_res1  <= len_do1;

        out_word.data     <= data_res1;
        out_word.keep_enc <= len_res1.keep_enc;
        out_word.last     <= len_res1.last;
        note.valid_bytes  <= to_valid_bytes(len_res1.keep_enc);
        note.last         <= len_res1.last;
        note.qid          <= deq_qid;
        rel_page          <= ptr_rsp.ptr.page;
    end

endmodule

/* rtl/enqueue_ctrl.sv */
// Ingress side. The next page is taken as soon as the last slot of a page is
// written; a packet crossing two pages flushes its first link mid-packet.
`include "pq_defs.svh"

module enqueue_ctrl (
    input  logic                packet_in,
    input  logic                rst,
    input  pq_pkg::pq_ingress_t in_word,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                ptr_req,
    input  logic                ptr_ack,
    output pq_pkg::ptr_req_t    ptr_cmd,
    input  pq_pkg::ptr_rsp_t    ptr_rsp,
    output logic                alloc,
    input  pq_pkg::page_t       alloc_page,
    input  logic                avail,
    output logic                wr_en,
    output pq_pkg::pq_ptr_t     wr_addr,
    output pq_pkg::pq_word_t    wr_word
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_PLACE,
        S_DATA,
        S_FLUSH,
        S_COMMIT
    } enq_state_t;

    enq_state_t       state;
    pq_pkg::pq_word_t held;
    pq_pkg::qid_t     cur_qid;
    logic             known;
    pq_pkg::pq_ptr_t  tail;
    logic             tail_ok;
    pq_pkg::words_t   words;
    logic             link_pend;
    pq_pkg::page_t    link_pg;
    logic             page_end;
    logic             need_alloc;
    logic             cross_blocked;
    logic             place;

    ////////////////////
    // Word placement

    assign page_end      = tail.offset == pq_pkg::offset_t'(`PQ_WORDS_PER_PAGE - 1);
    assign need_alloc    = !tail_ok || page_end;
    assign cross_blocked = page_end && link_pend;

    assign in_ready = !ptr_ack && ((state == S_IDLE) ||
                      (state == S_DATA && !cross_blocked && (!need_alloc || avail)));

    assign place   = (state == S_PLACE && (!need_alloc || avail)) ||
                     (state == S_DATA && in_valid && in_ready);
    assign alloc   = place && need_alloc;
    assign wr_en   = place;
    assign wr_word = (state == S_PLACE) ? held : in_word.word;
    // Without a tail page the word opens a new page at offset 0
    assign wr_addr = tail_ok ? tail : pq_pkg::pq_ptr_t'{page: alloc_page, offset: '0};

    // Plain tail read in S_READ since words and link_pend are both zero there
    always_comb begin
        ptr_cmd            = '0;
        ptr_cmd.op         = pq_pkg::PTR_TAIL_COMMIT;
        ptr_cmd.qid        = cur_qid;
        ptr_cmd.tail       = tail;
        ptr_cmd.words      = (state == S_COMMIT) ? words : '0;
        ptr_cmd.link_page  = link_pg;
        ptr_cmd.link_valid = link_pend;
    end

    ////////////////////
    // Control

    always_ff @(posedge packet_in) begin
        if (rst) begin
            state     <= S_IDLE;
            known     <= 1'b0;
            tail_ok   <= 1'b0;
            link_pend <= 1'b0;
            words     <= '0;
            ptr_req   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_valid && in_ready) begin
                        held    <= in_word.word;
                        cur_qid <= in_word.qid;
                        state   <= (known && cur_qid == in_word.qid) ? S_PLACE : S_READ;
                    end
                end
                S_DATA: begin
                    if (cross_blocked) begin
                        state <= S_FLUSH;
                    end
                end
                S_READ, S_FLUSH, S_COMMIT: begin
                    if (!ptr_req && !ptr_ack) begin
                        ptr_req <= 1'b1;
                    end
                    if (ptr_req && ptr_ack) begin
                        ptr_req <= 1'b0;
                        if (state == S_READ) begin
                            tail    <= ptr_rsp.ptr;
                            tail_ok <= !ptr_rsp.empty;
                            known   <= 1'b1;
                            state   <= S_PLACE;
                        end else if (state == S_FLUSH) begin
                            link_pend <= 1'b0;
                            state     <= S_DATA;
                        end else begin
                            link_pend <= 1'b0;
                            words     <= '0;
                            state     <= S_IDLE;
                        end
                    end
                end
                default: ;
            endcase

            if (place) begin
                words <= words + 1'b1;
                state <= wr_word.last ? S_COMMIT : S_DATA;
                if (!tail_ok) begin
                    tail      <= '{page: alloc_page, offset: pq_pkg::offset_t'(1)};
                    tail_ok   <= 1'b1;
                    link_pend <= 1'b1;
                    link_pg   <= alloc_page;
                end else if (page_end) begin
                    tail      <= '{page: alloc_page, offset: '0};
                    link_pend <= 1'b1;
                    link_pg   <= alloc_page;
                end else begin
                    tail.offset <= tail.offset + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/ptr_table_arbiter.sv */
// Four-phase req/ack arbiter for the pointer table. Clients must hold their
// request stable while req is high and keep req low until ack falls.
module ptr_table_arbiter (
    input  logic             packet_in,
    input  logic             rst,
    input  logic             enq_req,
    output logic             enq_ack,
    input  pq_pkg::ptr_req_t enq_cmd,
    output pq_pkg::ptr_rsp_t enq_rsp,
    input  logic             deq_req,
    output logic             deq_ack,
    input  pq_pkg::ptr_req_t deq_cmd,
    output pq_pkg::ptr_rsp_t deq_rsp,
    output logic             tbl_en,
    output pq_pkg::ptr_req_t tbl_req,
    input  pq_pkg::ptr_rsp_t tbl_rsp
);

    typedef enum logic [1:0] {
        A_IDLE,
        A_WAIT,
        A_ACK
    } arb_state_t;

    arb_state_t       state;
    logic             prio_deq;
    logic             pick_deq;
    logic             gnt_deq;
    pq_pkg::ptr_rsp_t rsp_q;

    // Dequeue wins when alone or when it holds the priority
    assign pick_deq = deq_req && (!enq_req || prio_deq);
    assign tbl_en   = (state == A_IDLE) && (enq_req || deq_req);
    assign tbl_req  = pick_deq ? deq_cmd : enq_cmd;
    assign enq_rsp  = rsp_q;
    assign deq_rsp  = rsp_q;

    always_ff @(posedge packet_in) begin
        if (rst) begin
            state    <= A_IDLE;
            prio_deq <= 1'b0;
            gnt_deq  <= 1'b0;
            enq_ack  <= 1'b0;
            deq_ack  <= 1'b0;
        end else begin
            case (state)
                A_IDLE: begin
                    if (tbl_en) begin
                        gnt_deq <= pick_deq;
                        state   <= A_WAIT;
                    end
                end
                A_WAIT: begin
                    // Table answer is valid one cycle after tbl_en
                    rsp_q   <= tbl_rsp;
                    enq_ack <= !gnt_deq;
                    deq_ack <= gnt_deq;
                    state   <= A_ACK;
                end
                A_ACK: begin
                    if (gnt_deq ? !deq_req : !enq_req) begin
                        enq_ack  <= 1'b0;
                        deq_ack  <= 1'b0;
                        prio_deq <= !gnt_deq;
                        state    <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

endmodule

/* rtl/queue_ptr_table.sv */
// Per-queue head, tail and word count plus the page link array. One access
// per tbl_en, answered in the next cycle.
`include "pq_defs.svh"

module queue_ptr_table (
    input  logic             packet_in,
    input  logic             rst,
    input  logic             tbl_en,
    input  pq_pkg::ptr_req_t tbl_req,
    output pq_pkg::ptr_rsp_t tbl_rsp
);

    pq_pkg::pq_ptr_t             head [`PQ_NUM_QUEUES];
    pq_pkg::pq_ptr_t             tail [`PQ_NUM_QUEUES];
    logic [`PQ_NUM_QUEUES-1:0]   tail_valid;
    logic [$bits(pq_pkg::words_t):0] count [`PQ_NUM_QUEUES];
    pq_pkg::page_t               link [`PQ_NUM_PAGES];
    pq_pkg::pq_ptr_t             cur_head;
    pq_pkg::pq_ptr_t             cur_tail;
    logic                        head_end;
    logic                        has_words;

    assign cur_head  = head[tbl_req.qid];
    assign cur_tail  = tail[tbl_req.qid];
    assign head_end  = cur_head.offset == pq_pkg::offset_t'(`PQ_WORDS_PER_PAGE - 1);
    assign has_words = count[tbl_req.qid] != '0;

    always_ff @(posedge packet_in) begin
        if (rst) begin
            tail_valid <= '0;
            tbl_rsp    <= '0;
            for (int q = 0; q < `PQ_NUM_QUEUES; q++) begin
                count[q] <= '0;
            end
        end else if (tbl_en) begin
            if (tbl_req.op == pq_pkg::PTR_HEAD_POP) begin
                tbl_rsp.ptr       <= cur_head;
                tbl_rsp.empty     <= !has_words;
                tbl_rsp.page_done <= has_words && head_end;
                if (has_words) begin
                    count[tbl_req.qid] <= count[tbl_req.qid] - 1'b1;
                    // Leaving a page follows its link to the next one
                    if (head_end) begin
                        head[tbl_req.qid] <= '{page: link[cur_head.page], offset: '0};
                    end else begin
                        head[tbl_req.qid].offset <= cur_head.offset + 1'b1;
                    end
                end
            end else begin
                tbl_rsp.ptr       <= cur_tail;
                tbl_rsp.empty     <= !tail_valid[tbl_req.qid];
                tbl_rsp.page_done <= 1'b0;
                count[tbl_req.qid] <= count[tbl_req.qid] + tbl_req.words;
                // First link of a fresh queue names its head page
                if (tbl_req.link_valid) begin
                    if (tail_valid[tbl_req.qid]) begin
                        link[cur_tail.page] <= tbl_req.link_page;
                    end else begin
                        head[tbl_req.qid] <= '{page: tbl_req.link_page, offset: '0};
                    end
                end
                // Zero words and no link is a plain tail read
                if (tbl_req.words != '0 || tbl_req.link_valid) begin
                    tail[tbl_req.qid]       <= tbl_req.tail;
                    tail_valid[tbl_req.qid] <= 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/page_free_list.sv */
// Circular list of free pages, full after reset. A release is only legal for
// a page that was allocated, so the list never overflows.
`include "pq_defs.svh"

module page_free_list (
    input  logic              packet_in,
    input  logic              rst,
    input  logic              alloc,
    output pq_pkg::page_t     alloc_page,
    output logic              avail,
    input  logic              rel,
    input  pq_pkg::page_t     rel_page,
    output pq_pkg::page_cnt_t pages_free
);

    pq_pkg::page_t list [`PQ_NUM_PAGES];
    pq_pkg::page_t rd_ptr;
    pq_pkg::page_t wr_ptr;
    logic          take;

    assign avail      = pages_free != '0;
    assign alloc_page = list[rd_ptr];
    assign take       = alloc && avail;

    always_ff @(posedge packet_in) begin
        if (rst) begin
            // Every page starts out free, in ascending order
            for (int i = 0; i < `PQ_NUM_PAGES; i++) begin
                list[i] <= pq_pkg::page_t'(i);
            end
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            pages_free <= pq_pkg::page_cnt_t'(`PQ_NUM_PAGES);
        end else begin
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rel) begin
                list[wr_ptr] <= rel_page;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            pages_free <= pages_free + pq_pkg::page_cnt_t'(rel)
                          - pq_pkg::page_cnt_t'(take);
        end
    end

endmodule

/* rtl/pq_pkg.sv */
// Shared types of the packet queue. All widths follow the size macros.
`include "pq_defs.svh"

package pq_pkg;

    typedef logic [$clog2(`PQ_NUM_PAGES)-1:0]      page_t;
    typedef logic [$clog2(`PQ_WORDS_PER_PAGE)-1:0] offset_t;
    typedef logic [$clog2(`PQ_NUM_QUEUES)-1:0]     qid_t;
    typedef logic [$clog2(`PQ_DATA_BYTES)-1:0]     keep_enc_t;
    typedef logic [$clog2(`PQ_DATA_BYTES):0]       valid_bytes_t;
    typedef logic [$clog2(`PQ_NUM_PAGES*`PQ_WORDS_PER_PAGE)-1:0] words_t;
    typedef logic [$clog2(`PQ_NUM_PAGES):0]        page_cnt_t;

    // keep_enc of 0 means every byte is valid, n means n valid bytes
    typedef struct packed {
        logic [`PQ_DATA_BYTES*8-1:0] data;
        keep_enc_t                   keep_enc;
        logic                        last;
    } pq_word_t;

    typedef struct packed {
        pq_word_t word;
        qid_t     qid;
    } pq_ingress_t;

    // Page and offset together form the word memory address
    typedef struct packed {
        page_t   page;
        offset_t offset;
    } pq_ptr_t;

    typedef enum logic {
        PTR_HEAD_POP,
        PTR_TAIL_COMMIT
    } ptr_op_t;

    typedef struct packed {
        ptr_op_t op;
        qid_t    qid;
        pq_ptr_t tail;
        words_t  words;
        page_t   link_page;
        logic    link_valid;
    } ptr_req_t;

    // For a commit, empty means the queue has no tail page yet
    typedef struct packed {
        pq_ptr_t ptr;
        logic    empty;
        logic    page_done;
    } ptr_rsp_t;

    typedef struct packed {
        valid_bytes_t valid_bytes;
        logic         last;
        qid_t         qid;
    } deq_note_t;

endpackage

/* include/pq_defs.svh */
// Size settings for the packet queue. Pages, words per page and bytes per
// word must be powers of two.
`ifndef PQ_DEFS_SVH
`define PQ_DEFS_SVH

// Bytes carried by one memory word
`define PQ_DATA_BYTES     4

// Words held by one page
`define PQ_WORDS_PER_PAGE 4

// Pages in the word memory
`define PQ_NUM_PAGES      16

// Egress queues
`define PQ_NUM_QUEUES     4

`endif
